/* all.f */
+incdir+source
source/slam_seq_pkg.sv
source/slam_assoc_pkg.sv
source/state_vec_ram.sv
source/ekf_phase_seq.sv
source/state_vec_map.sv
source/slam_state_top.sv
verification/tb_slam_state.sv

/* verification/tb_slam_state.sv */
`timescale 1ns/100ps
`include "slam_settings.svh"

module tb_slam_state;

  import slam_seq_pkg::*;
  import slam_assoc_pkg::*;

  localparam int DW         = `SLAM_DW;
  localparam int MAX_CYCLES = 4000;
  localparam int UPD_BLOCKS = 3;

  // Output selectors for the compare process
  localparam int SEL_XK     = 0;
  localparam int SEL_YK     = 1;
  localparam int SEL_XITA   = 2;
  localparam int SEL_LKX    = 3;
  localparam int SEL_LKY    = 4;
  localparam int SEL_LK     = 5;
  localparam int SEL_STATUS = 6;
  localparam int SEL_BUSY   = 7;
  localparam int SEL_CNEXT  = 8;

  logic                       clk;
  logic                       sys_rst;
  logic                       i_cmd_valid;
  slam_op_e                   i_cmd;
  logic [`SLAM_LK_W-1:0]      i_lk;
  logic [`SLAM_UPD_BLK_W-1:0] i_upd_blocks;
  logic signed [DW-1:0]       i_x_hat;
  logic signed [DW-1:0]       i_y_hat;
  logic signed [DW-1:0]       i_xita_hat;
  logic signed [DW-1:0]       i_lkx_hat;
  logic signed [DW-1:0]       i_lky_hat;
  logic signed [4*DW-1:0]     i_corr;
  logic signed [DW-1:0]       i_mahal;
  logic                       o_busy;
  logic signed [DW-1:0]       o_xk;
  logic signed [DW-1:0]       o_yk;
  logic signed [DW-1:0]       o_xita;
  logic signed [DW-1:0]       o_lkx;
  logic signed [DW-1:0]       o_lky;
  logic                       o_corr_next;
  assoc_status_e              o_assoc_status;
  logic [`SLAM_LK_W-1:0]      o_assoc_lk;

  // Reference copy of the low state words
  logic [DW-1:0]         model_mem [64];
  logic [4*DW-1:0]       corr_vec [UPD_BLOCKS];
  logic [DW-1:0]         rnd_a;
  logic [DW-1:0]         rnd_b;
  logic [DW-1:0]         rnd_c;
  logic [DW-1:0]         ref_min;
  logic [`SLAM_LK_W-1:0] ref_lk;

  string         exp_name [$];
  int            exp_sel [$];
  logic [DW-1:0] exp_val [$];
  event          check_ev;

  int err_cnt = 0;
  int chk_cnt = 0;
  int cyc_cnt = 0;
  int corr_pulses = 0;

  slam_state_top UUT (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .i_lk           (i_lk),
    .i_upd_blocks   (i_upd_blocks),
    .i_x_hat        (i_x_hat),
    .i_y_hat        (i_y_hat),
    .i_xita_hat     (i_xita_hat),
    .i_lkx_hat      (i_lkx_hat),
    .i_lky_hat      (i_lky_hat),
    .i_corr         (i_corr),
    .i_mahal        (i_mahal),
    .o_busy         (o_busy),
    .o_xk           (o_xk),
    .o_yk           (o_yk),
    .o_xita         (o_xita),
    .o_lkx          (o_lkx),
    .o_lky          (o_lky),
    .o_corr_next    (o_corr_next),
    .o_assoc_status (o_assoc_status),
    .o_assoc_lk     (o_assoc_lk)
  );

  always #10 clk = ~clk;

  function automatic logic [DW-1:0] corrected_word(input logic [DW-1:0] word,
                                                   input logic [DW-1:0] corr);
    return word + corr;
  endfunction

  // Gate the minimum distance against both chi-square thresholds
  function automatic assoc_status_e gate_status(input logic [DW-1:0] dmin);
    assoc_status_e st;
    if (dmin < `SLAM_CHI_95) begin
      st = ASSOC_UPD;
    end else if (dmin > `SLAM_CHI_999) begin
      st = ASSOC_NEW;
    end else begin
      st = ASSOC_FAIL;
    end
    return st;
  endfunction

  // Distance magnitude below, between or above the gates
  function automatic logic [DW-1:0] assoc_mag(input int run);
    logic [DW-1:0] mag;
    case (run)
      0:       mag = $urandom % 32'h0005_0000;
      1:       mag = 32'h0006_0000 + $urandom % 32'h0007_0000;
      default: mag = 32'h000E_0000 + $urandom % 32'h00F0_0000;
    endcase
    return mag;
  endfunction

  function automatic logic [DW-1:0] dut_value(input int sel);
    logic [DW-1:0] val;
    case (sel)
      SEL_XK:     val = o_xk;
      SEL_YK:     val = o_yk;
      SEL_XITA:   val = o_xita;
      SEL_LKX:    val = o_lkx;
      SEL_LKY:    val = o_lky;
      SEL_LK:     val = o_assoc_lk;
      SEL_STATUS: val = o_assoc_status;
      SEL_BUSY:   val = o_busy;
      default:    val = o_corr_next;
    endcase
    return val;
  endfunction

  task automatic expect_out(input string name, input int sel, input logic [DW-1:0] val);
    exp_name.push_back(name);
    exp_sel.push_back(sel);
    exp_val.push_back(val);
  endtask

  always @(check_ev) begin : compare_proc
    string         name;
    int            sel;
    logic [DW-1:0] exp_v;
    logic [DW-1:0] act_v;
    while (exp_val.size() > 0) begin
      name  = exp_name.pop_front();
      sel   = exp_sel.pop_front();
      exp_v = exp_val.pop_front();
      act_v = dut_value(sel);
      chk_cnt++;
      if (act_v !== exp_v) begin
        err_cnt++;
        $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
      end
    end
  end

  // Strobe one command and wait for busy to drop
  task automatic run_cmd(input slam_op_e op, input string tag);
    @(posedge clk);
    i_cmd       <= op;
    i_cmd_valid <= 1'b1;
    @(posedge clk);
    i_cmd_valid <= 1'b0;
    @(negedge clk);
    if (!o_busy) begin
      err_cnt++;
      $display("%s: command was not accepted, busy stayed low", tag);
    end
    while (o_busy) begin
      // Next correction vector once the current one is used
      if (o_corr_next) begin
        corr_pulses++;
        if (corr_pulses < UPD_BLOCKS) begin
          @(posedge clk);
          i_corr <= corr_vec[corr_pulses];
        end
      end
      @(negedge clk);
    end
  endtask

  task automatic read_check(input string tag, input int lk);
    int base;
    base = 2 * (lk + 1);
    @(posedge clk);
    i_lk <= lk;
    run_cmd(OP_READ_STATE, tag);
    expect_out($sformatf("%s xk", tag), SEL_XK, model_mem[`SLAM_XK_ADDR]);
    expect_out($sformatf("%s yk", tag), SEL_YK, model_mem[`SLAM_YK_ADDR]);
    expect_out($sformatf("%s xita", tag), SEL_XITA, model_mem[`SLAM_XITA_ADDR]);
    expect_out($sformatf("%s lkx", tag), SEL_LKX, model_mem[base]);
    expect_out($sformatf("%s lky", tag), SEL_LKY, model_mem[base+1]);
    -> check_ev;
  endtask

  initial begin
    void'($urandom(32'h12b20535));
    clk          = 1'b0;
    sys_rst      = 1'b1;
    i_cmd_valid  = 1'b0;
    i_cmd        = OP_READ_STATE;
    i_lk         = '0;
    i_upd_blocks = '0;
    i_x_hat      = '0;
    i_y_hat      = '0;
    i_xita_hat   = '0;
    i_lkx_hat    = '0;
    i_lky_hat    = '0;
    i_corr       = '0;
    i_mahal      = '0;
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = '0;
    end

    repeat (4) @(posedge clk);
    sys_rst <= 1'b0;
    @(negedge clk);
    expect_out("reset busy", SEL_BUSY, '0);
    expect_out("reset corr_next", SEL_CNEXT, '0);
    expect_out("reset status", SEL_STATUS, ASSOC_WAIT);
    expect_out("reset assoc_lk", SEL_LK, '0);
    -> check_ev;

    // Pose write and read-back
    rnd_a = $urandom;
    rnd_b = $urandom;
    rnd_c = $urandom;
    @(posedge clk);
    i_x_hat    <= rnd_a;
    i_y_hat    <= rnd_b;
    i_xita_hat <= rnd_c;
    model_mem[`SLAM_XK_ADDR]   = rnd_a;
    model_mem[`SLAM_YK_ADDR]   = rnd_b;
    model_mem[`SLAM_XITA_ADDR] = rnd_c;
    run_cmd(OP_WRITE_POSE, "write_pose");
    read_check("read_pose", 1);

    // Landmarks 1 to 5
    for (int lk = 1; lk <= 5; lk++) begin
      rnd_a = $urandom;
      rnd_b = $urandom;
      @(posedge clk);
      i_lk      <= lk;
      i_lkx_hat <= rnd_a;
      i_lky_hat <= rnd_b;
      model_mem[2*(lk+1)]   = rnd_a;
      model_mem[2*(lk+1)+1] = rnd_b;
      run_cmd(OP_INIT_LM, $sformatf("init_lm%0d", lk));
    end
    for (int lk = 1; lk <= 5; lk++) begin
      read_check($sformatf("read_lm%0d", lk), lk);
    end

    // Three update blocks over words 0 to 11
    for (int b = 0; b < UPD_BLOCKS; b++) begin
      corr_vec[b] = {$urandom, $urandom, $urandom, $urandom};
      for (int s = 0; s < 4; s++) begin
        model_mem[4*b+s] = corrected_word(model_mem[4*b+s], corr_vec[b][s*DW +: DW]);
      end
    end
    @(posedge clk);
    i_upd_blocks <= UPD_BLOCKS;
    i_corr       <= corr_vec[0];
    corr_pulses = 0;
    run_cmd(OP_UPDATE, "update");
    if (corr_pulses != UPD_BLOCKS) begin
      err_cnt++;
      $display("ERR update corr_next count: expected %0d, actual %0d",
               UPD_BLOCKS, corr_pulses);
    end
    for (int lk = 1; lk <= 4; lk++) begin
      read_check($sformatf("upd_lm%0d", lk), lk);
    end

    // Association runs below, between and above the gates
    for (int r = 0; r < 3; r++) begin
      for (int lk = 1; lk <= 4; lk++) begin
        rnd_a = assoc_mag(r);
        rnd_b = ($urandom % 2) ? (~rnd_a + 1'b1) : rnd_a;
        @(posedge clk);
        i_lk    <= lk;
        i_mahal <= rnd_b;
        run_cmd(OP_ASSOC, $sformatf("assoc%0d_lm%0d", r, lk));
        // Status lands one cycle after busy drops
        @(negedge clk);
        if (lk == 1 || rnd_a < ref_min) begin
          ref_min = rnd_a;
          ref_lk  = lk;
        end
        expect_out($sformatf("assoc%0d_lm%0d lk", r, lk), SEL_LK, ref_lk);
        expect_out($sformatf("assoc%0d_lm%0d status", r, lk), SEL_STATUS,
                   gate_status(ref_min));
        expect_out($sformatf("assoc%0d_lm%0d lkx", r, lk), SEL_LKX, model_mem[2*(lk+1)]);
        expect_out($sformatf("assoc%0d_lm%0d lky", r, lk), SEL_LKY, model_mem[2*(lk+1)+1]);
        -> check_ev;
      end
    end

    repeat (2) @(negedge clk);
    if (exp_val.size() != 0) begin
      err_cnt++;
      $display("compare process left %0d checks undone", exp_val.size());
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    while (cyc_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cyc_cnt++;
    end
    err_cnt++;
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* source/slam_state_top.sv */
`timescale 1ns/100ps
`include "slam_settings.svh"

module slam_state_top (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  logic                            i_cmd_valid,
  input  slam_seq_pkg::slam_op_e          i_cmd,
  input  logic [`SLAM_LK_W-1:0]           i_lk,
  input  logic [`SLAM_UPD_BLK_W-1:0]      i_upd_blocks,
  input  logic signed [`SLAM_DW-1:0]      i_x_hat,
  input  logic signed [`SLAM_DW-1:0]      i_y_hat,
  input  logic signed [`SLAM_DW-1:0]      i_xita_hat,
  input  logic signed [`SLAM_DW-1:0]      i_lkx_hat,
  input  logic signed [`SLAM_DW-1:0]      i_lky_hat,
  input  logic signed [4*`SLAM_DW-1:0]    i_corr,
  input  logic signed [`SLAM_DW-1:0]      i_mahal,
  output logic                            o_busy,
  output logic signed [`SLAM_DW-1:0]      o_xk,
  output logic signed [`SLAM_DW-1:0]      o_yk,
  output logic signed [`SLAM_DW-1:0]      o_xita,
  output logic signed [`SLAM_DW-1:0]      o_lkx,
  output logic signed [`SLAM_DW-1:0]      o_lky,
  output logic                            o_corr_next,
  output slam_assoc_pkg::assoc_status_e   o_assoc_status,
  output logic [`SLAM_LK_W-1:0]           o_assoc_lk
);

  import slam_seq_pkg::*;

  slam_phase_e                phase;
  logic [`SLAM_SEQ_W-1:0]     seq;
  logic                       ram_en;
  logic                       ram_we;
  logic [`SLAM_ADDR_W-1:0]    ram_addr;
  logic signed [`SLAM_DW-1:0] ram_din;
  logic signed [`SLAM_DW-1:0] ram_dout;

  ekf_phase_seq u_seq (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd        (i_cmd),
    .i_upd_blocks (i_upd_blocks),
    .o_phase      (phase),
    .o_seq        (seq),
    .o_busy       (o_busy)
  );

  state_vec_map u_map (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_phase        (phase),
    .i_seq          (seq),
    .i_lk           (i_lk),
    .i_x_hat        (i_x_hat),
    .i_y_hat        (i_y_hat),
    .i_xita_hat     (i_xita_hat),
    .i_lkx_hat      (i_lkx_hat),
    .i_lky_hat      (i_lky_hat),
    .i_corr         (i_corr),
    .i_mahal        (i_mahal),
    .i_ram_dout     (ram_dout),
    .o_ram_en       (ram_en),
    .o_ram_we       (ram_we),
    .o_ram_addr     (ram_addr),
    .o_ram_din      (ram_din),
    .o_xk           (o_xk),
    .o_yk           (o_yk),
    .o_xita         (o_xita),
    .o_lkx          (o_lkx),
    .o_lky          (o_lky),
    .o_corr_next    (o_corr_next),
    .o_assoc_status (o_assoc_status),
    .o_assoc_lk     (o_assoc_lk)
  );

  state_vec_ram u_ram (
    .clk    (clk),
    .i_en   (ram_en),
    .i_we   (ram_we),
    .i_addr (ram_addr),
    .i_din  (ram_din),
    .o_dout (ram_dout)
  );

endmodule

/* source/state_vec_map.sv */
`timescale 1ns/100ps
`include "slam_settings.svh"

module state_vec_map (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  slam_seq_pkg::slam_phase_e       i_phase,
  input  logic [`SLAM_SEQ_W-1:0]          i_seq,
  input  logic [`SLAM_LK_W-1:0]           i_lk,
  input  logic signed [`SLAM_DW-1:0]      i_x_hat,
  input  logic signed [`SLAM_DW-1:0]      i_y_hat,
  input  logic signed [`SLAM_DW-1:0]      i_xita_hat,
  input  logic signed [`SLAM_DW-1:0]      i_lkx_hat,
  input  logic signed [`SLAM_DW-1:0]      i_lky_hat,
  input  logic signed [4*`SLAM_DW-1:0]    i_corr,
  input  logic signed [`SLAM_DW-1:0]      i_mahal,
  input  logic signed [`SLAM_DW-1:0]      i_ram_dout,
  output logic                            o_ram_en,
  output logic                            o_ram_we,
  output logic [`SLAM_ADDR_W-1:0]         o_ram_addr,
  output logic signed [`SLAM_DW-1:0]      o_ram_din,
  output logic signed [`SLAM_DW-1:0]      o_xk,
  output logic signed [`SLAM_DW-1:0]      o_yk,
  output logic signed [`SLAM_DW-1:0]      o_xita,
  output logic signed [`SLAM_DW-1:0]      o_lkx,
  output logic signed [`SLAM_DW-1:0]      o_lky,
  output logic                            o_corr_next,
  output slam_assoc_pkg::assoc_status_e   o_assoc_status,
  output logic [`SLAM_LK_W-1:0]           o_assoc_lk
);

  import slam_seq_pkg::*;
  import slam_assoc_pkg::*;

  localparam logic [`SLAM_ADDR_W-1:0] XK_ADDR   = `SLAM_XK_ADDR;
  localparam logic [`SLAM_ADDR_W-1:0] YK_ADDR   = `SLAM_YK_ADDR;
  localparam logic [`SLAM_ADDR_W-1:0] XITA_ADDR = `SLAM_XITA_ADDR;
  localparam logic [`SLAM_DW-1:0]     CHI_95    = `SLAM_CHI_95;
  localparam logic [`SLAM_DW-1:0]     CHI_999   = `SLAM_CHI_999;

  logic [`SLAM_ADDR_W-1:0]    lk_num;
  logic [`SLAM_ADDR_W-1:0]    lk_base;
  logic                       is_send;

  slam_phase_e                ph_dly  [`SLAM_UPD_DELAY];
  logic [`SLAM_SEQ_W-1:0]     seq_dly [`SLAM_UPD_DELAY];
  logic                       upd_d;
  logic [`SLAM_SEQ_W-1:0]     seq_d;
  logic [`SLAM_ADDR_W-1:0]    upd_base;
  logic [1:0]                 slice_idx;
  logic signed [`SLAM_DW-1:0] corr_slice;
  logic signed [`SLAM_DW-1:0] upd_sum [4];

  logic                       ram_en_nx;
  logic                       ram_we_nx;
  logic [`SLAM_ADDR_W-1:0]    ram_addr_nx;
  logic signed [`SLAM_DW-1:0] ram_din_nx;

  logic [`SLAM_DW-1:0]        chi_abs;
  logic [`SLAM_DW-1:0]        chi_tmp;
  logic [`SLAM_DW-1:0]        chi_min;
  logic                       cmp_d;

  assign is_send = (i_phase == PH_NL_SEND) || (i_phase == PH_ASSOC_SEND);

  // Landmark k lives at 2(k+1)
  assign lk_num = `SLAM_ADDR_W'(i_lk);

  always_ff @(posedge clk) begin
    lk_base <= (lk_num + 1'b1) << 1;
  end

  // Align phase and step with the correction path
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < `SLAM_UPD_DELAY; i++) begin
        ph_dly[i] <= PH_IDLE;
      end
    end else begin
      ph_dly[0] <= i_phase;
      for (int i = 1; i < `SLAM_UPD_DELAY; i++) begin
        ph_dly[i] <= ph_dly[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    seq_dly[0] <= i_seq;
    for (int i = 1; i < `SLAM_UPD_DELAY; i++) begin
      seq_dly[i] <= seq_dly[i-1];
    end
  end

  assign upd_d = (ph_dly[`SLAM_UPD_DELAY-1] == PH_UPD_STATE);
  assign seq_d = seq_dly[`SLAM_UPD_DELAY-1];

  // Four words per block
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      upd_base <= '0;
    end else if (!upd_d) begin
      upd_base <= '0;
    end else if (seq_d == SEQ_UPD_LAST) begin
      upd_base <= upd_base + 3'd4;
    end
  end

  // Read data for step n arrives at step n+2
  assign slice_idx  = seq_d[1:0] - 2'd2;
  assign corr_slice = i_corr[slice_idx*`SLAM_DW +: `SLAM_DW];

  always_ff @(posedge clk) begin
    if (upd_d && (seq_d >= 2) && (seq_d <= 5)) begin
      upd_sum[slice_idx] <= i_ram_dout + corr_slice;
    end
  end

  assign o_corr_next = upd_d && (seq_d == 5);

  always_comb begin
    ram_en_nx   = 1'b0;
    ram_we_nx   = 1'b0;
    ram_addr_nx = o_ram_addr;
    ram_din_nx  = o_ram_din;
    if (is_send) begin
      ram_en_nx = (i_seq <= 4);
      case (i_seq)
        0:       ram_addr_nx = XK_ADDR;
        1:       ram_addr_nx = YK_ADDR;
        2:       ram_addr_nx = XITA_ADDR;
        3:       ram_addr_nx = lk_base;
        4:       ram_addr_nx = lk_base + 1'b1;
        default: ram_en_nx = 1'b0;
      endcase
    end else if (i_phase == PH_POSE_RCV && i_seq < SEQ_POSE_LAST) begin
      ram_en_nx = 1'b1;
      ram_we_nx = 1'b1;
      case (i_seq)
        0:       {ram_addr_nx, ram_din_nx} = {XK_ADDR, i_x_hat};
        1:       {ram_addr_nx, ram_din_nx} = {YK_ADDR, i_y_hat};
        default: {ram_addr_nx, ram_din_nx} = {XITA_ADDR, i_xita_hat};
      endcase
    end else if (i_phase == PH_LM_RCV && i_seq < SEQ_LM_LAST) begin
      ram_en_nx   = 1'b1;
      ram_we_nx   = 1'b1;
      ram_addr_nx = lk_base + i_seq[0];
      ram_din_nx  = i_seq[0] ? i_lky_hat : i_lkx_hat;
    end else if (upd_d) begin
      // Steps 0-3 read, steps 4-7 write the sums back
      ram_en_nx   = 1'b1;
      ram_we_nx   = seq_d[2];
      ram_addr_nx = upd_base + seq_d[1:0];
      ram_din_nx  = upd_sum[seq_d[1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_ram_en <= 1'b0;
      o_ram_we <= 1'b0;
    end else begin
      o_ram_en <= ram_en_nx;
      o_ram_we <= ram_we_nx;
    end
  end

  always_ff @(posedge clk) begin
    o_ram_addr <= ram_addr_nx;
    o_ram_din  <= ram_din_nx;
  end

  // Capture read-out for the nonlinear unit
  always_ff @(posedge clk) begin
    if (is_send) begin
      case (i_seq)
        2:             o_xk   <= i_ram_dout;
        3:             o_yk   <= i_ram_dout;
        4:             o_xita <= i_ram_dout;
        5:             o_lkx  <= i_ram_dout;
        SEQ_SEND_LAST: o_lky  <= i_ram_dout;
        default:       ;
      endcase
    end
  end

  // Nearest neighbour on |mahalanobis|
  assign chi_abs = i_mahal[`SLAM_DW-1] ? $unsigned(-i_mahal) : $unsigned(i_mahal);

  always_ff @(posedge clk) begin
    if (i_phase == PH_ASSOC_EVAL && i_seq == SEQ_CHI_LOAD) begin
      chi_tmp <= chi_abs;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      chi_min        <= '0;
      o_assoc_lk     <= '0;
      cmp_d          <= 1'b0;
      o_assoc_status <= ASSOC_WAIT;
    end else begin
      cmp_d <= (i_phase == PH_ASSOC_EVAL) && (i_seq == SEQ_CHI_CMP);
      // First landmark restarts the search
      if (i_phase == PH_ASSOC_EVAL && i_seq == SEQ_CHI_CMP) begin
        if (i_lk == `SLAM_LK_W'(1) || chi_tmp < chi_min) begin
          chi_min    <= chi_tmp;
          o_assoc_lk <= i_lk;
        end
      end
      if (cmp_d) begin
        if (chi_min < CHI_95) begin
          o_assoc_status <= ASSOC_UPD;
        end else if (chi_min > CHI_999) begin
          o_assoc_status <= ASSOC_NEW;
        end else begin
          o_assoc_status <= ASSOC_FAIL;
        end
      end
    end
  end

  // Delayed update writes never meet a send or receive phase
  a_upd_clear: assert property (@(posedge clk) disable iff (sys_rst)
    upd_d |-> !(is_send || i_phase == PH_POSE_RCV || i_phase == PH_LM_RCV));

  // Last word of a block stays inside the memory
  a_upd_addr: assert property (@(posedge clk) disable iff (sys_rst)
    upd_d |-> ({1'b0, upd_base} + 3) < (1 << `SLAM_ADDR_W));

endmodule

/* source/ekf_phase_seq.sv */
`timescale 1ns/100ps
`include "slam_settings.svh"

module ekf_phase_seq (
  input  logic                          clk,
  input  logic                          sys_rst,
  input  logic                          i_cmd_valid,
  input  slam_seq_pkg::slam_op_e        i_cmd,
  input  logic [`SLAM_UPD_BLK_W-1:0]    i_upd_blocks,
  output slam_seq_pkg::slam_phase_e     o_phase,
  output logic [`SLAM_SEQ_W-1:0]        o_seq,
  output logic                          o_busy
);

  import slam_seq_pkg::*;

  // Drain covers the delayed update writes
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_DRAIN_LAST = `SLAM_UPD_DELAY;

  slam_phase_e                  phase_nx;
  logic [`SLAM_SEQ_W-1:0]       seq_nx;
  logic [`SLAM_UPD_BLK_W-1:0]   blk_cnt;

  always_comb begin
    phase_nx = o_phase;
    seq_nx   = o_seq + 1'b1;
    case (o_phase)
      PH_IDLE: begin
        seq_nx = '0;
        if (i_cmd_valid) begin
          case (i_cmd)
            OP_READ_STATE: phase_nx = PH_NL_SEND;
            OP_WRITE_POSE: phase_nx = PH_POSE_RCV;
            OP_INIT_LM:    phase_nx = PH_LM_RCV;
            // Zero blocks only drains
            OP_UPDATE:     phase_nx = (i_upd_blocks == '0) ? PH_UPD_DRAIN : PH_UPD_STATE;
            OP_ASSOC:      phase_nx = PH_ASSOC_SEND;
            default:       phase_nx = PH_IDLE;
          endcase
        end
      end
      PH_NL_SEND: begin
        if (o_seq == SEQ_SEND_LAST) phase_nx = PH_IDLE;
      end
      PH_POSE_RCV: begin
        if (o_seq == SEQ_POSE_LAST) phase_nx = PH_IDLE;
      end
      PH_LM_RCV: begin
        if (o_seq == SEQ_LM_LAST) phase_nx = PH_IDLE;
      end
      PH_UPD_STATE: begin
        if (o_seq == SEQ_UPD_LAST) begin
          seq_nx = '0;
          if (blk_cnt == i_upd_blocks - 1'b1) phase_nx = PH_UPD_DRAIN;
        end
      end
      PH_UPD_DRAIN: begin
        if (o_seq == SEQ_DRAIN_LAST) phase_nx = PH_IDLE;
      end
      PH_ASSOC_SEND: begin
        if (o_seq == SEQ_SEND_LAST) phase_nx = PH_ASSOC_EVAL;
      end
      PH_ASSOC_EVAL: begin
        if (o_seq == SEQ_CHI_CMP) phase_nx = PH_IDLE;
      end
      default: phase_nx = PH_IDLE;
    endcase
    // Every new phase starts at step 0
    if (phase_nx != o_phase) begin
      seq_nx = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_phase <= PH_IDLE;
      o_seq   <= '0;
      o_busy  <= 1'b0;
      blk_cnt <= '0;
    end else begin
      o_phase <= phase_nx;
      o_seq   <= seq_nx;
      o_busy  <= (phase_nx != PH_IDLE);
      if (o_phase != PH_UPD_STATE) begin
        blk_cnt <= '0;
      end else if (o_seq == SEQ_UPD_LAST) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
    end
  end

  // Block count stays below the requested blocks
  a_blk_range: assert property (@(posedge clk) disable iff (sys_rst)
    (o_phase == PH_UPD_STATE) |-> (blk_cnt < i_upd_blocks));

endmodule

/* source/state_vec_ram.sv */
`timescale 1ns/100ps
`include "slam_settings.svh"

module state_vec_ram (
  input  logic                       clk,
  input  logic                       i_en,
  input  logic                       i_we,
  input  logic [`SLAM_ADDR_W-1:0]    i_addr,
  input  logic signed [`SLAM_DW-1:0] i_din,
  output logic signed [`SLAM_DW-1:0] o_dout
);

  localparam int DEPTH = 1 << `SLAM_ADDR_W;

  logic signed [`SLAM_DW-1:0] mem [DEPTH];

  // State vector starts out all zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Output register keeps its value during writes
  always @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_din;
      end else begin
        o_dout <= mem[i_addr];
      end
    end
  end

endmodule

/* source/slam_assoc_pkg.sv */
package slam_assoc_pkg;

  // Gated result of nearest-neighbour association
  typedef enum logic [1:0] {
    ASSOC_WAIT = 2'b00,
    ASSOC_NEW  = 2'b01,
    ASSOC_UPD  = 2'b10,
    ASSOC_FAIL = 2'b11
  } assoc_status_e;

endpackage

/* source/slam_seq_pkg.sv */
`include "slam_settings.svh"

package slam_seq_pkg;

  // Command opcodes
  typedef enum logic [2:0] {
    OP_READ_STATE = 3'd0,
    OP_WRITE_POSE = 3'd1,
    OP_INIT_LM    = 3'd2,
    OP_UPDATE     = 3'd3,
    OP_ASSOC      = 3'd4
  } slam_op_e;

  // Sequencer phases
  typedef enum logic [3:0] {
    PH_IDLE       = 4'd0,
    PH_NL_SEND    = 4'd1,
    PH_POSE_RCV   = 4'd2,
    PH_LM_RCV     = 4'd3,
    PH_UPD_STATE  = 4'd4,
    PH_UPD_DRAIN  = 4'd5,
    PH_ASSOC_SEND = 4'd6,
    PH_ASSOC_EVAL = 4'd7
  } slam_phase_e;

  // Last step of the pose and landmark read-out
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_SEND_LAST = 6;

  // Last step of the write-back phases
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_POSE_LAST = 3;
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_LM_LAST   = 2;

  // Update block wraps after step 7
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_UPD_LAST  = 7;

  // Association eval steps
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_CHI_LOAD  = 10;
  localparam logic [`SLAM_SEQ_W-1:0] SEQ_CHI_CMP   = 11;

endpackage

/* source/slam_settings.svh */
`ifndef SLAM_SETTINGS_SVH
`define SLAM_SETTINGS_SVH

// State word, signed Q16.16
`define SLAM_DW          32

// Landmark number and sequencer step widths
`define SLAM_LK_W        10
`define SLAM_SEQ_W       5

// State memory, 1024 words
`define SLAM_ADDR_W      10

// Fixed pose word addresses
`define SLAM_XK_ADDR     1
`define SLAM_YK_ADDR     2
`define SLAM_XITA_ADDR   3

// Correction path latency in cycles
`define SLAM_UPD_DELAY   8

// Width of the update block count
`define SLAM_UPD_BLK_W   8

// Chi-square gates in Q16.16, 5.99147 and 13.8155
`define SLAM_CHI_95      32'h0005_FDD1
`define SLAM_CHI_999     32'h000D_D0C5

`endif
